/* verilog/lsu_pkg.sv */
/*
 * lsu package
 * Memory opcode and issue state encodings shared by the load/store
 * unit of the RV32 memory stage, plus the AXI response code that
 * counts as success.
 */
package lsu_pkg;

    // funct3 encoding; stores reuse lb/lh/lw as byte/half/word size
    typedef enum logic [2:0] {
        op_lb  = 3'b000,
        op_lh  = 3'b001,
        op_lw  = 3'b010,
        op_lbu = 3'b100,
        op_lhu = 3'b101
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_read  = 2'b01, // ar sent or pending, waiting on r
        st_write = 2'b10  // aw/w sent or pending, waiting on b
    } issue_state_e;

    localparam logic [1:0] resp_okay = 2'b00;

endpackage

/* verilog/lsu_issue.sv */
/*
 * lsu issue
 * Accepts the execute bundle and runs at most one single-beat AXI
 * read or write at a time. Reports completion with a one-cycle
 * mem_done pulse and flags a non-OKAY response as a fault.
 */
module lsu_issue
    import lsu_pkg::*;
#(
    parameter int addr_width = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  in_is_load,
    input  logic                  in_is_store,
    input  mem_op_e               in_op,
    input  logic [31:0]           in_alu_result,
    input  logic                  out_free,
    output logic                  mem_done,
    output logic                  mem_fault,
    output logic [31:0]           mem_load_data,
    output mem_op_e               op_q,
    output logic [1:0]            offset_q,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [addr_width-1:0] awaddr,
    output logic [2:0]            awsize,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    input  logic [1:0]            bresp,
    output logic                  arvalid,
    input  logic                  arready,
    output logic [addr_width-1:0] araddr,
    output logic [2:0]            arsize,
    input  logic                  rvalid,
    output logic                  rready,
    input  logic [1:0]            rresp,
    input  logic [31:0]           load_data
);

    issue_state_e          state;
    logic [addr_width-1:0] addr_q;
    logic                  accept;
    logic                  r_fire;
    logic                  b_fire;

    assign in_ready = (state == st_idle) && out_free;
    assign accept   = in_valid && in_ready;
    assign r_fire   = (state == st_read) && rvalid && rready;
    assign b_fire   = (state == st_write) && bvalid && bready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && in_is_load) begin
                        state   <= st_read;
                        arvalid <= 1'b1;
                        rready  <= 1'b1; // ready for r as soon as ar goes out
                    end else if (accept && in_is_store) begin
                        state   <= st_write;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        bready  <= 1'b1;
                    end
                end
                st_read: begin
                    if (arvalid && arready)
                        arvalid <= 1'b0;
                    if (r_fire) begin
                        rready <= 1'b0;
                        state  <= st_idle;
                    end
                end
                st_write: begin
                    if (awvalid && awready)
                        awvalid <= 1'b0;
                    if (wvalid && wready)
                        wvalid <= 1'b0;
                    if (b_fire) begin
                        bready <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and op only change for memory ops
    always_ff @(posedge clock) begin
        if (accept && (in_is_load || in_is_store)) begin
            addr_q <= in_alu_result[addr_width-1:0];
            op_q   <= in_op;
        end
    end

    always_ff @(posedge clock) begin
        if (accept)
            mem_load_data <= '0; // stays zero for stores
        else if (r_fire)
            mem_load_data <= load_data;
    end

    assign mem_done  = r_fire || b_fire;
    assign mem_fault = (r_fire && rresp != resp_okay) || (b_fire && bresp != resp_okay);

    assign offset_q = addr_q[1:0];
    assign awaddr   = addr_q;
    assign araddr   = addr_q;
    assign awsize   = {1'b0, op_q[1:0]}; // unsigned loads share the size code
    assign arsize   = {1'b0, op_q[1:0]};

    a_w_with_aw: assert property (@(posedge clock) disable iff (reset)
        $rose(wvalid) |-> awvalid);
    a_r_in_read: assert property (@(posedge clock) disable iff (reset)
        rvalid |-> state == st_read);
    a_b_in_write: assert property (@(posedge clock) disable iff (reset)
        bvalid |-> state == st_write);

endmodule

/* verilog/lsu_store_align.sv */
/*
 * lsu store align
 * Places the store data on the byte lanes selected by the low address
 * bits and builds the matching AXI write strobes.
 */
module lsu_store_align
    import lsu_pkg::*;
(
    input  mem_op_e     op_q,
    input  logic [1:0]  offset_q,
    input  logic [31:0] store_data_q,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb
);

    logic [3:0] strb_base;

    always_comb begin
        case (op_q)
            op_lb:   strb_base = 4'b0001;
            op_lh:   strb_base = 4'b0011;
            default: strb_base = 4'b1111; // word
        endcase
    end

    assign wdata = store_data_q << {offset_q, 3'b000};
    assign wstrb = strb_base << offset_q;

    // halves stay inside one word
    always_comb begin
        if (op_q == op_lh || op_q == op_lhu)
            a_half_aligned: assert #0 (!offset_q[0]);
    end

endmodule

/* verilog/lsu_load_align.sv */
/*
 * lsu load align
 * Picks the addressed byte or half out of the AXI read data and
 * sign- or zero-extends it by the load opcode. Words pass unchanged.
 */
module lsu_load_align
    import lsu_pkg::*;
(
    input  mem_op_e     op_q,
    input  logic [1:0]  offset_q,
    input  logic [31:0] rdata,
    output logic [31:0] load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = rdata[{offset_q, 3'b000} +: 8];
    assign sel_half = rdata[{offset_q[1], 4'b0000} +: 16]; // lower or upper half

    always_comb begin
        case (op_q)
            op_lb: begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            op_lh: begin
                load_data = {{16{sel_half[15]}}, sel_half};
            end
            op_lbu: begin
                load_data = {24'd0, sel_byte};
            end
            op_lhu: begin
                load_data = {16'd0, sel_half};
            end
            default: begin
                load_data = rdata;
            end
        endcase
    end

endmodule

/* verilog/lsu_writeback.sv */
/*
 * lsu writeback
 * Output register toward writeback. Holds the pass-through fields
 * from acceptance and presents the result until out_ready takes it.
 * Memory ops become valid on the mem_done pulse.
 */
module lsu_writeback (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_fire,
    input  logic        in_is_mem,
    input  logic [31:0] in_pc,
    input  logic [4:0]  in_rd,
    input  logic        in_reg_wen,
    input  logic [31:0] in_alu_result,
    input  logic        mem_done,
    input  logic        mem_fault,
    input  logic [31:0] mem_load_data,
    output logic        out_free,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_pc,
    output logic [4:0]  out_rd,
    output logic        out_reg_wen,
    output logic [31:0] out_wb_data,
    output logic        out_fault
);

    logic        is_mem_q;
    logic [31:0] alu_q;

    assign out_free = !out_valid || out_ready; // empty or draining now

    always_ff @(posedge clock) begin
        if (reset)
            out_valid <= 1'b0;
        else if (in_fire)
            out_valid <= !in_is_mem; // memory ops wait for the bus
        else if (mem_done)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (in_fire) begin
            out_pc      <= in_pc;
            out_rd      <= in_rd;
            out_reg_wen <= in_reg_wen;
            alu_q       <= in_alu_result;
            is_mem_q    <= in_is_mem;
            out_fault   <= 1'b0;
        end else if (mem_done) begin
            out_fault <= mem_fault;
        end
    end

    // load data already zero for stores
    assign out_wb_data = is_mem_q ? mem_load_data : alu_q;

    a_done_when_empty: assert property (@(posedge clock) disable iff (reset)
        mem_done |-> !out_valid);

endmodule

/* verilog/lsu_stage.sv */
/*
 * lsu stage
 * Memory stage of the RV32 pipeline. Connects the issue, alignment
 * and writeback blocks, keeps the captured store data and ties the
 * fixed single-beat AXI4 fields.
 */
module lsu_stage
    import lsu_pkg::*;
#(
    parameter int addr_width = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_pc,
    input  logic [4:0]            in_rd,
    input  logic                  in_reg_wen,
    input  logic                  in_is_load,
    input  logic                  in_is_store,
    input  mem_op_e               in_op,
    input  logic [31:0]           in_alu_result,
    input  logic [31:0]           in_store_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [31:0]           out_pc,
    output logic [4:0]            out_rd,
    output logic                  out_reg_wen,
    output logic [31:0]           out_wb_data,
    output logic                  out_fault,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [addr_width-1:0] awaddr,
    output logic [3:0]            awid,
    output logic [7:0]            awlen,
    output logic [2:0]            awsize,
    output logic [1:0]            awburst,
    output logic                  wvalid,
    input  logic                  wready,
    output logic [31:0]           wdata,
    output logic [3:0]            wstrb,
    output logic                  wlast,
    input  logic                  bvalid,
    output logic                  bready,
    input  logic [1:0]            bresp,
    output logic                  arvalid,
    input  logic                  arready,
    output logic [addr_width-1:0] araddr,
    output logic [3:0]            arid,
    output logic [7:0]            arlen,
    output logic [2:0]            arsize,
    output logic [1:0]            arburst,
    input  logic                  rvalid,
    output logic                  rready,
    input  logic [31:0]           rdata,
    input  logic [1:0]            rresp
);

    logic        in_fire;
    logic        out_free;
    logic        mem_done;
    logic        mem_fault;
    logic [31:0] mem_load_data;
    logic [31:0] load_data;
    logic [31:0] store_data_q;
    mem_op_e     op_q;
    logic [1:0]  offset_q;

    assign in_fire = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (in_fire && in_is_store)
            store_data_q <= in_store_data;
    end

    // single beat, fixed burst, id 0
    assign awid    = 4'd0;
    assign awlen   = 8'd0;
    assign awburst = 2'b00;
    assign arid    = 4'd0;
    assign arlen   = 8'd0;
    assign arburst = 2'b00;
    assign wlast   = wvalid;

    lsu_issue #(
        .addr_width(addr_width)
    ) i_issue (
        .clock, .reset, .in_valid, .in_ready, .in_is_load, .in_is_store, .in_op,
        .in_alu_result, .out_free, .mem_done, .mem_fault, .mem_load_data,
        .op_q, .offset_q, .awvalid, .awready, .awaddr, .awsize, .wvalid, .wready,
        .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .arsize,
        .rvalid, .rready, .rresp, .load_data
    );

    lsu_store_align i_store_align (
        .op_q, .offset_q, .store_data_q, .wdata, .wstrb
    );

    lsu_load_align i_load_align (
        .op_q, .offset_q, .rdata, .load_data
    );

    lsu_writeback i_writeback (
        .clock, .reset, .in_fire,
        .in_is_mem(in_is_load || in_is_store),
        .in_pc, .in_rd, .in_reg_wen, .in_alu_result, .mem_done, .mem_fault,
        .mem_load_data, .out_free, .out_valid, .out_ready, .out_pc, .out_rd,
        .out_reg_wen, .out_wb_data, .out_fault
    );

endmodule

/* tests/axi_mem_model.sv */
/*
 * axi memory model
 * Behavioural single-beat AXI4 slave over a 256-byte memory. Ready and
 * response delays are random from 0 to 3 cycles. Accesses inside the
 * error window answer SLVERR and leave the memory untouched.
 */
module axi_mem_model
    import lsu_pkg::*;
#(
    parameter int          addr_width = 32,
    parameter logic [31:0] err_base   = 32'h100,
    parameter logic [31:0] err_size   = 32'h40
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_width-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] resp_slverr = 2'b10;

    logic [7:0]            mem [0:255];
    logic [1:0]            aw_wait;
    logic [1:0]            w_wait;
    logic [1:0]            ar_wait;
    logic [1:0]            r_wait;
    logic                  aw_got;
    logic                  w_got;
    logic                  ar_got;
    logic [addr_width-1:0] aw_addr_q;
    logic [addr_width-1:0] ar_addr_q;
    logic [31:0]           w_data_q;
    logic [3:0]            w_strb_q;

    function automatic logic in_err_window(input logic [addr_width-1:0] addr);
        return (32'(addr) >= err_base) && (32'(addr) < err_base + err_size);
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            bresp   <= resp_okay;
            rresp   <= resp_okay;
            rdata   <= 32'd0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_wait <= 2'($urandom % 4);
            w_wait  <= 2'($urandom % 4);
            ar_wait <= 2'($urandom % 4);
            r_wait  <= 2'($urandom % 4);
            for (int i = 0; i < 256; i++)
                mem[i] <= 8'(i * 7 + 49); // fill pattern
        end else begin
            if (awvalid && awready) begin
                awready   <= 1'b0;
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
                aw_wait   <= 2'($urandom % 4);
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 2'd0)
                    awready <= 1'b1;
                else
                    aw_wait <= aw_wait - 2'd1;
            end
            if (wvalid && wready) begin
                wready   <= 1'b0;
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
                w_wait   <= 2'($urandom % 4);
            end else if (wvalid && !w_got) begin
                if (w_wait == 2'd0)
                    wready <= 1'b1;
                else
                    w_wait <= w_wait - 2'd1;
            end
            if (aw_got && w_got) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                if (in_err_window(aw_addr_q)) begin
                    bresp <= resp_slverr; // no write in the window
                end else begin
                    bresp <= resp_okay;
                    for (int i = 0; i < 4; i++)
                        if (w_strb_q[i])
                            mem[{aw_addr_q[7:2], 2'(i)}] <= w_data_q[8*i +: 8];
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                arready   <= 1'b0;
                ar_got    <= 1'b1;
                ar_addr_q <= araddr;
                ar_wait   <= 2'($urandom % 4);
            end else if (arvalid && !ar_got) begin
                if (ar_wait == 2'd0)
                    arready <= 1'b1;
                else
                    ar_wait <= ar_wait - 2'd1;
            end
            if (ar_got && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    ar_got <= 1'b0;
                    r_wait <= 2'($urandom % 4);
                    rdata  <= {mem[{ar_addr_q[7:2], 2'd3}], mem[{ar_addr_q[7:2], 2'd2}],
                               mem[{ar_addr_q[7:2], 2'd1}], mem[{ar_addr_q[7:2], 2'd0}]};
                    rresp  <= in_err_window(ar_addr_q) ? resp_slverr : resp_okay;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* tests/tb_lsu_stage.sv */
/*
 * lsu stage testbench
 * Directed tests for the RV32 memory stage against an AXI memory model:
 * pass-through, loads, stores, back-pressure, faults and a random mix.
 * Expected values come from a reference byte memory kept here.
 */
module tb_lsu_stage
    import lsu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int addr_width     = 16;
    localparam int timeout_cycles = 100;

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    logic [31:0]           in_pc;
    logic [4:0]            in_rd;
    logic                  in_reg_wen;
    logic                  in_is_load;
    logic                  in_is_store;
    mem_op_e               in_op;
    logic [31:0]           in_alu_result;
    logic [31:0]           in_store_data;
    logic                  out_valid;
    logic                  out_ready;
    logic [31:0]           out_pc;
    logic [4:0]            out_rd;
    logic                  out_reg_wen;
    logic [31:0]           out_wb_data;
    logic                  out_fault;
    logic                  awvalid;
    logic                  awready;
    logic [addr_width-1:0] awaddr;
    logic [3:0]            awid;
    logic [7:0]            awlen;
    logic [2:0]            awsize;
    logic [1:0]            awburst;
    logic                  wvalid;
    logic                  wready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wlast;
    logic                  bvalid;
    logic                  bready;
    logic [1:0]            bresp;
    logic                  arvalid;
    logic                  arready;
    logic [addr_width-1:0] araddr;
    logic [3:0]            arid;
    logic [7:0]            arlen;
    logic [2:0]            arsize;
    logic [1:0]            arburst;
    logic                  rvalid;
    logic                  rready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;

    int          checks;
    int          errors;
    logic        bp_mode;
    string       cur_name;
    logic [31:0] pc_next;
    logic [31:0] exp_pc;
    logic [31:0] exp_alu;
    logic [4:0]  exp_rd;
    logic        exp_wen;
    mem_op_e     exp_op;
    logic [7:0]  ref_mem [0:255];
    mem_op_e     load_ops [5] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu};
    mem_op_e     store_ops [3] = '{op_lb, op_lh, op_lw};

    lsu_stage #(.addr_width(addr_width)) i_dut (.*);

    axi_mem_model #(
        .addr_width(addr_width),
        .err_base(32'h100),
        .err_size(32'h40)
    ) i_mem (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    function automatic int access_size(input mem_op_e op);
        case (op)
            op_lb, op_lbu: return 1;
            op_lh, op_lhu: return 2;
            default:       return 4;
        endcase
    endfunction

    // log2 of the bytes per beat
    function automatic logic [2:0] size_code(input mem_op_e op);
        case (access_size(op))
            1:       return 3'd0;
            2:       return 3'd1;
            default: return 3'd2;
        endcase
    endfunction

    function automatic logic [31:0] random_addr(input mem_op_e op);
        logic [31:0] base;
        base = 32'(($urandom % 64) * 4);
        return base + 32'(($urandom % 4) & ~(access_size(op) - 1)); // legal offset only
    endfunction

    // addressed bytes, extended by the RV32 load rules
    function automatic logic [31:0] expect_load(input mem_op_e op, input logic [7:0] addr);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[addr];
        b1 = ref_mem[addr + 8'd1];
        case (op)
            op_lb:   return {{24{b0[7]}}, b0};
            op_lbu:  return {24'd0, b0};
            op_lh:   return {{16{b1[7]}}, b1, b0};
            op_lhu:  return {16'd0, b1, b0};
            default: return {ref_mem[addr + 8'd3], ref_mem[addr + 8'd2], b1, b0};
        endcase
    endfunction

    task automatic store_ref(input mem_op_e op, input logic [7:0] addr, input logic [31:0] data);
        for (int i = 0; i < access_size(op); i++)
            ref_mem[addr + 8'(i)] = data[8*i +: 8];
    endtask

    task automatic set_back_pressure(input logic on);
        bp_mode = on;
        out_ready <= !on;
    endtask

    // single beat, fixed burst, id 0, size and address of the open access
    always @(negedge clock) begin
        if (!reset) begin
            if (wvalid)
                check_eq({cur_name, " wlast"}, 32'd1, 32'(wlast));
            if (arvalid) begin
                check_eq({cur_name, " araddr"}, 32'(exp_alu[addr_width-1:0]), 32'(araddr));
                check_eq({cur_name, " arsize"}, 32'(size_code(exp_op)), 32'(arsize));
                check_eq({cur_name, " arid"}, 32'd0, 32'(arid));
                check_eq({cur_name, " arlen"}, 32'd0, 32'(arlen));
                check_eq({cur_name, " arburst"}, 32'd0, 32'(arburst));
            end
            if (awvalid) begin
                check_eq({cur_name, " awaddr"}, 32'(exp_alu[addr_width-1:0]), 32'(awaddr));
                check_eq({cur_name, " awsize"}, 32'(size_code(exp_op)), 32'(awsize));
                check_eq({cur_name, " awid"}, 32'd0, 32'(awid));
                check_eq({cur_name, " awlen"}, 32'd0, 32'(awlen));
                check_eq({cur_name, " awburst"}, 32'd0, 32'(awburst));
            end
        end
    end

    task automatic drive_bundle(input logic is_load, input logic is_store, input mem_op_e op,
                                input logic [31:0] alu, input logic [31:0] sdata);
        exp_pc  = pc_next;
        exp_rd  = 5'($urandom);
        exp_wen = 1'($urandom);
        exp_alu = alu;
        exp_op  = op;
        pc_next = pc_next + 32'd4;
        in_valid      <= 1'b1;
        in_pc         <= exp_pc;
        in_rd         <= exp_rd;
        in_reg_wen    <= exp_wen;
        in_is_load    <= is_load;
        in_is_store   <= is_store;
        in_op         <= op;
        in_alu_result <= alu;
        in_store_data <= sdata;
    endtask

    // returns on the accepting edge
    task automatic wait_accept(input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!in_ready && waited < timeout_cycles) begin
            @(negedge clock);
            waited++;
        end
        assert (in_ready) else begin
            errors++;
            $display("%s: in_ready stayed low and the bundle was never accepted", name);
        end
        @(posedge clock);
    endtask

    task automatic receive(input string name, input logic [31:0] exp_data,
                           input logic exp_fault, input logic check_data);
        int waited;
        int hold;
        waited = 0;
        @(negedge clock);
        while (!out_valid && waited < timeout_cycles) begin
            @(negedge clock);
            waited++;
        end
        assert (out_valid) else begin
            errors++;
            $display("%s: no result came back before the timeout", name);
        end
        if (out_valid) begin
            check_eq({name, " pc"}, exp_pc, out_pc);
            check_eq({name, " rd"}, 32'(exp_rd), 32'(out_rd));
            check_eq({name, " reg_wen"}, 32'(exp_wen), 32'(out_reg_wen));
            check_eq({name, " fault"}, 32'(exp_fault), 32'(out_fault));
            if (check_data)
                check_eq({name, " data"}, exp_data, out_wb_data);
            hold = bp_mode ? int'($urandom % 4) : 0;
            repeat (hold) begin
                @(negedge clock);
                check_eq({name, " held valid"}, 32'd1, 32'(out_valid));
                check_eq({name, " held pc"}, exp_pc, out_pc);
                if (check_data)
                    check_eq({name, " held data"}, exp_data, out_wb_data);
                check_eq({name, " in_ready under back-pressure"}, 32'd0, 32'(in_ready));
            end
            if (bp_mode) begin
                @(posedge clock);
                out_ready <= 1'b1;
            end
            @(posedge clock); // result taken
            out_ready <= !bp_mode;
            @(negedge clock);
            check_eq({name, " valid after take"}, 32'd0, 32'(out_valid));
        end
        @(posedge clock);
    endtask

    task automatic do_op(input string name, input logic is_load, input logic is_store,
                         input mem_op_e op, input logic [31:0] alu, input logic [31:0] sdata,
                         input logic exp_fault);
        logic [31:0] exp_data;
        if (is_load)
            exp_data = expect_load(op, alu[7:0]);
        else if (is_store)
            exp_data = 32'd0;
        else
            exp_data = alu;
        if (is_store && !exp_fault)
            store_ref(op, alu[7:0], sdata);
        cur_name = name;
        drive_bundle(is_load, is_store, op, alu, sdata);
        wait_accept(name);
        in_valid <= 1'b0;
        receive(name, exp_data, exp_fault, !(is_load && exp_fault));
    endtask

    task automatic random_op(input string tag);
        int      kind;
        mem_op_e op;
        kind = int'($urandom % 3);
        if (kind == 0) begin
            op = load_ops[$urandom % 5];
            do_op({tag, " load"}, 1'b1, 1'b0, op, random_addr(op), 32'd0, 1'b0);
        end else if (kind == 1) begin
            op = store_ops[$urandom % 3];
            do_op({tag, " store"}, 1'b0, 1'b1, op, random_addr(op), $urandom, 1'b0);
        end else begin
            do_op({tag, " alu"}, 1'b0, 1'b0, op_lw, $urandom, 32'd0, 1'b0);
        end
    endtask

    // back-to-back bundles, each result one cycle after acceptance
    task automatic test_pass_through();
        logic [31:0] pend_alu;
        logic [31:0] pend_pc;
        logic        pending;
        logic        accept;
        int          sent;
        int          got;
        int          waited;
        set_back_pressure(1'b0);
        cur_name = "pass_through";
        sent = 0;
        got = 0;
        waited = 0;
        pending = 1'b0;
        drive_bundle(1'b0, 1'b0, op_lw, $urandom, 32'd0);
        while (got < 8 && waited < timeout_cycles) begin
            @(negedge clock);
            waited++;
            check_eq("pass_through out_valid", 32'(pending), 32'(out_valid));
            if (in_valid)
                check_eq("pass_through in_ready", 32'd1, 32'(in_ready));
            if (pending) begin
                check_eq("pass_through data", pend_alu, out_wb_data);
                check_eq("pass_through pc", pend_pc, out_pc);
                got++;
            end
            accept = in_valid && in_ready;
            @(posedge clock);
            pending = accept;
            if (accept) begin
                pend_alu = exp_alu;
                pend_pc = exp_pc;
                sent++;
                if (sent < 8)
                    drive_bundle(1'b0, 1'b0, op_lw, $urandom, 32'd0);
                else
                    in_valid <= 1'b0;
            end
        end
        assert (got == 8) else begin
            errors++;
            $display("pass_through: only %0d of 8 results arrived before the timeout", got);
        end
    endtask

    task automatic test_loads();
        logic [31:0] base;
        mem_op_e     op;
        set_back_pressure(1'b0);
        for (int k = 0; k < 5; k++) begin
            op = load_ops[k];
            base = 32'(($urandom % 64) * 4);
            for (int off = 0; off < 4; off += access_size(op))
                do_op({"load ", op.name()}, 1'b1, 1'b0, op, base + 32'(off), 32'd0, 1'b0);
        end
    endtask

    task automatic test_stores();
        logic [31:0] base;
        mem_op_e     op;
        set_back_pressure(1'b0);
        for (int k = 0; k < 3; k++) begin
            op = store_ops[k];
            base = 32'(($urandom % 64) * 4);
            for (int off = 0; off < 4; off += access_size(op)) begin
                do_op({"store ", op.name()}, 1'b0, 1'b1, op, base + 32'(off), $urandom, 1'b0);
                do_op("store readback", 1'b1, 1'b0, op_lw, base, 32'd0, 1'b0);
            end
        end
    endtask

    task automatic test_back_pressure();
        set_back_pressure(1'b1);
        repeat (12)
            random_op("back_pressure");
        set_back_pressure(1'b0);
    endtask

    task automatic test_faults();
        set_back_pressure(1'b0);
        do_op("fault load", 1'b1, 1'b0, op_lw, 32'h104, 32'd0, 1'b1);
        do_op("clean load", 1'b1, 1'b0, op_lh, 32'h42, 32'd0, 1'b0);
        do_op("fault store", 1'b0, 1'b1, op_lw, 32'h120, 32'hdeadbeef, 1'b1);
        do_op("clean store", 1'b0, 1'b1, op_lb, 32'h21, 32'h5a, 1'b0);
        do_op("alias readback", 1'b1, 1'b0, op_lw, 32'h20, 32'd0, 1'b0); // window write dropped
    endtask

    task automatic test_mixed();
        repeat (40) begin
            set_back_pressure(1'($urandom));
            random_op("mixed");
        end
        set_back_pressure(1'b0);
    endtask

    initial begin
        void'($urandom(32'h815d031a));
        checks = 0;
        errors = 0;
        bp_mode = 1'b0;
        cur_name = "reset";
        pc_next = 32'h0000_1000;
        for (int i = 0; i < 256; i++)
            ref_mem[i] = 8'(i * 7 + 49);
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = 32'd0;
        in_rd = 5'd0;
        in_reg_wen = 1'b0;
        in_is_load = 1'b0;
        in_is_store = 1'b0;
        in_op = op_lw;
        in_alu_result = 32'd0;
        in_store_data = 32'd0;
        out_ready = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        test_pass_through();
        test_loads();
        test_stores();
        test_back_pressure();
        test_faults();
        test_mixed();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* lsu_stage.f */
verilog/lsu_pkg.sv
verilog/lsu_issue.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_writeback.sv
verilog/lsu_stage.sv
tests/axi_mem_model.sv
tests/tb_lsu_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the lsu_stage testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f lsu_stage.f --top-module tb_lsu_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lsu_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
